/* project.f */
hdl/grabber_pkg.sv
hdl/sample_gate.sv
hdl/ycc_to_rgb.sv
hdl/dark_detect.sv
hdl/frame_writer.sv
hdl/frame_buffer.sv
hdl/frame_grabber.sv
sim/grabber_checker.sv
sim/tb_frame_grabber.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_frame_grabber \
   -f project.f -o sim_frame_grabber || { echo "build failed"; exit 1; }

out="$(./obj_dir/sim_frame_grabber)"
echo "$out"
echo "$out" | grep -qx "No errors" && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

/* sim/tb_frame_grabber.sv */
// testbench top with clock, reset, video fields, reference pixel model and host read-back
`timescale 1ns/1ps

module tb_frame_grabber;

   localparam int ADDR_W     = 6;
   localparam int GROUP_SKIP = 1;
   localparam int GROUPS     = 8;                // groups per line
   localparam int WORDS      = 2**ADDR_W;        // words per bank
   localparam int LINE_CYC   = 4*GROUPS + 8;     // bytes plus blanking
   localparam int FIELD_CYC  = 60;               // syncs, irq wait and read-back
   localparam int LIMIT      = 20*LINE_CYC + 4*FIELD_CYC + 10 + 200;

   logic              clk_llc = 1'b0;
   logic              resetx, vref, href, odd, host_rd;
   logic [7:0]        vpo;
   logic [ADDR_W:0]   host_adr;
   logic [15:0]       host_data;
   logic [15:0]       exp_data;
   logic              host_valid, irq0, irq1;
   logic [15:0]       model_mem [2*WORDS];   // expected content of both banks
   bit                written [2*WORDS];
   integer            seed = 32'h6e13_9b6d;
   int                line_cnt = 0;          // href rises since reset
   int                bank = 0;
   int                wr_ptr = 0;
   int                active_fields = 0;
   int                cycles = 0;
   int                tb_errors = 0;
   int                chk_errors, chk_count, irq_count;

   always #5 clk_llc = ~clk_llc;

   frame_grabber #(.ADDR_W(ADDR_W), .GROUP_SKIP(GROUP_SKIP)) frame_grabber_inst (
      .clk_llc, .resetx, .vref, .href, .odd, .vpo,
      .host_adr, .host_rd, .host_data, .host_valid, .irq0, .irq1
   );

   grabber_checker #(.ADDR_W(ADDR_W)) checker_inst (
      .clk_llc, .resetx, .host_rd, .host_adr, .exp_data, .host_data, .host_valid,
      .irq0, .irq1, .error_count(chk_errors), .check_count(chk_count),
      .irq_count(irq_count)
   );

   //----------------------------------------------------------------------
   // reference model from YCbCr over saturated RGB565 to a dark or light word
   //----------------------------------------------------------------------
   function automatic int abs_diff(input int a, input int b);
      return (a > b) ? a - b : b - a;
   endfunction

   function automatic int clamp_channel(input int s, input int lsb, input int ones);
      if (s < 0)
         return 0;
      else if (s >= (1 << 18))   // bit 18 or 19 set
         return ones;
      else
         return (s >> lsb) & ones;
   endfunction

   function automatic logic [15:0] ref_pixel(input int y, input int cb, input int cr);
      int yv, cbv, crv;
      int r, g, b, gh;
      yv  = 4*y - 64;
      cbv = 4*cb - 512;
      crv = 4*cr - 512;
      r   = clamp_channel(298*yv + 408*crv, 13, 31);
      g   = clamp_channel(298*yv - 208*crv - 100*cbv, 12, 63);
      b   = clamp_channel(298*yv + 516*cbv, 13, 31);
      gh  = g >> 1;
      if (abs_diff(b, r) <= 2 && abs_diff(gh, b) <= 3 && abs_diff(gh, r) <= 3 &&
          r < 8 && g < 15 && b < 8)
         return 16'h0000;
      return 16'hFFFF;
   endfunction

   //----------------------------------------------------------------------
   // video and host tasks
   //----------------------------------------------------------------------
   task automatic send_line(input bit active);
      logic [7:0] grp [4];   // cb, y, cr, y
      int         g;
      int         k;
      line_cnt++;
      for (g = 0; g < GROUPS; g++)
      begin
         if (($random(seed) & 3) == 0)
         begin
            grp[1] = 8'(16 + ($random(seed) & 15));   // near black grey
            grp[0] = 8'(126 + ($random(seed) & 3));
            grp[2] = 8'(126 + ($random(seed) & 3));
         end
         else
         begin
            grp[0] = 8'($random(seed));
            grp[1] = 8'($random(seed));
            grp[2] = 8'($random(seed));
         end
         grp[3] = 8'($random(seed));
         if (active && line_cnt % 2 == 1 && g % (GROUP_SKIP + 1) == 0)
         begin
            model_mem[bank*WORDS + wr_ptr] = ref_pixel(grp[1], grp[0], grp[2]);
            written[bank*WORDS + wr_ptr]   = 1'b1;
            wr_ptr++;
         end
         for (k = 0; k < 4; k++)
         begin
            @(posedge clk_llc);
            href <= 1'b1;
            vpo  <= grp[k];
         end
      end
      @(posedge clk_llc);
      href <= 1'b0;
      vpo  <= 8'h00;
      repeat (7) @(posedge clk_llc);   // horizontal blanking
   endtask

   task automatic wait_irq();
      @(posedge clk_llc);
      while (!(irq0 || irq1))
         @(posedge clk_llc);
      while (irq0 || irq1)
         @(posedge clk_llc);
   endtask

   task automatic send_field(input bit odd_lvl, input int lines);
      int n;
      @(posedge clk_llc);
      odd  <= odd_lvl;
      vref <= 1'b1;
      if (odd_lvl)
      begin
         bank   = 1 - bank;   // flips on each field start
         wr_ptr = 0;
         active_fields++;
      end
      repeat (4) @(posedge clk_llc);
      for (n = 0; n < lines; n++)
         send_line(odd_lvl);
      repeat (10) @(posedge clk_llc);
      vref <= 1'b0;
      if (odd_lvl)
         wait_irq();
      else
         repeat (8) @(posedge clk_llc);   // no field, no irq
   endtask

   task automatic read_bank(input int bk);
      int a;
      for (a = 0; a < WORDS; a++)
      begin
         if (written[bk*WORDS + a])
         begin
            @(posedge clk_llc);
            host_rd  <= 1'b1;
            host_adr <= (ADDR_W+1)'(bk*WORDS + a);
            exp_data <= model_mem[bk*WORDS + a];
         end
      end
      @(posedge clk_llc);
      host_rd <= 1'b0;
      repeat (2) @(posedge clk_llc);
   endtask

   //----------------------------------------------------------------------
   // test sequence
   //----------------------------------------------------------------------
   initial
   begin
      resetx   <= 1'b0;
      vref     <= 1'b0;
      href     <= 1'b0;
      odd      <= 1'b0;
      vpo      <= '0;
      host_rd  <= 1'b0;
      host_adr <= '0;
      exp_data <= '0;
      repeat (2) @(posedge clk_llc);
      resetx <= 1'b1;
      send_field(1'b1, 6);   // fills bank 1
      read_bank(1);
      send_field(1'b1, 6);   // fills bank 0
      read_bank(0);
      read_bank(1);
      send_field(1'b0, 4);   // even field, nothing written
      read_bank(0);
      read_bank(1);
      send_field(1'b1, 4);   // bank 1 again, shorter, tail kept
      read_bank(0);
      read_bank(1);
      repeat (4) @(posedge clk_llc);
      if (irq_count != active_fields)
      begin
         $display("wrong number of interrupt pulses, expected %0d, saw %0d",
                  active_fields, irq_count);
         tb_errors++;
      end
      $display("checks %0d, checker errors %0d, testbench errors %0d",
               chk_count, chk_errors, tb_errors);
      if (chk_errors + tb_errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

   always @(posedge clk_llc)
   begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT)
      begin
         $display("timeout after %0d cycles, checks %0d, checker errors %0d",
                  LIMIT, chk_count, chk_errors);
         $display("Errors found");
         $finish;
      end
   end

endmodule

/* sim/grabber_checker.sv */
// checker for host read latency and data, interrupt width and bank order
`timescale 1ns/1ps

module grabber_checker #(
   parameter int ADDR_W = 6
)
(
   input  logic            clk_llc,
   input  logic            resetx,
   input  logic            host_rd,
   input  logic [ADDR_W:0] host_adr,
   input  logic [15:0]     exp_data,
   input  logic [15:0]     host_data,
   input  logic            host_valid,
   input  logic            irq0,
   input  logic            irq1,
   output int              error_count,
   output int              check_count,
   output int              irq_count
);

   logic            rd_d;
   logic [ADDR_W:0] adr_d;
   logic [15:0]     exp_d;
   int              len0;
   int              len1;
   logic            next_irq1;   // bank 1 finishes first

   always @(posedge clk_llc)
   begin
      if (!resetx)
      begin
         if (irq0 !== 1'b0 || irq1 !== 1'b0 || host_valid !== 1'b0)
         begin
            $display("irq or host_valid not low during reset at %0t", $time);
            error_count = error_count + 1;
         end
         rd_d      <= 1'b0;
         len0      = 0;
         len1      = 0;
         next_irq1 = 1'b0;
      end
      else
      begin
         rd_d  <= host_rd;
         adr_d <= host_adr;
         exp_d <= exp_data;
         //-------------------------------------------------------------------
         // read port with one cycle latency
         //-------------------------------------------------------------------
         if (host_valid !== rd_d)
         begin
            $display("Mismatch at %0t: host_valid expected %0b got %0b", $time, rd_d, host_valid);
            error_count = error_count + 1;
         end
         else if (host_valid)
         begin
            check_count = check_count + 1;
            if (host_data !== exp_d)
            begin
               $display("Mismatch at %0t: host_data[%0d] expected %h got %h",
                        $time, adr_d, exp_d, host_data);
               error_count = error_count + 1;
            end
         end
         //-------------------------------------------------------------------
         // interrupts
         //-------------------------------------------------------------------
         if (irq0 && irq1)
         begin
            $display("irq0 and irq1 both high at %0t", $time);
            error_count = error_count + 1;
         end
         if ((irq0 && len0 == 0) || (irq1 && len1 == 0))   // pulse start
         begin
            irq_count   = irq_count + 1;
            check_count = check_count + 1;
            if (irq1 !== next_irq1)
            begin
               $display("Mismatch at %0t: irq1 expected %0b got %0b", $time, next_irq1, irq1);
               error_count = error_count + 1;
            end
            next_irq1 = ~next_irq1;
         end
         if (!irq0 && len0 != 0 && len0 != 2)
         begin
            $display("irq0 pulse ending at %0t lasted %0d cycles instead of 2", $time, len0);
            error_count = error_count + 1;
         end
         if (!irq1 && len1 != 0 && len1 != 2)
         begin
            $display("irq1 pulse ending at %0t lasted %0d cycles instead of 2", $time, len1);
            error_count = error_count + 1;
         end
         len0 = irq0 ? len0 + 1 : 0;
         len1 = irq1 ? len1 + 1 : 0;
      end
   end

endmodule

/* hdl/frame_grabber.sv */
// top level chaining sampler, converter, dark detector, writer and memory
`timescale 1ns/1ps

module frame_grabber #(
   parameter int ADDR_W     = 15,
   parameter int GROUP_SKIP = 1
)
(
   input  logic                             clk_llc,
   input  logic                             resetx,
   input  logic                             vref,
   input  logic                             href,
   input  logic                             odd,
   input  logic [grabber_pkg::SAMPLE_W-1:0] vpo,
   input  logic [ADDR_W:0]                  host_adr,
   input  logic                             host_rd,
   output logic [grabber_pkg::PIX_W-1:0]    host_data,
   output logic                             host_valid,
   output logic                             irq0,
   output logic                             irq1
);

   import grabber_pkg::*;

   //----------------------------------------------------------------------
   // stage links
   //----------------------------------------------------------------------
   logic                     samp_valid;
   logic [SAMPLE_W-1:0]      samp_y, samp_cb, samp_cr;
   logic                     rgb_valid;
   logic signed [PROD_W-1:0] sum_r, sum_g, sum_b;
   logic                     pix_valid;
   logic [PIX_W-1:0]         pix_data;
   logic                     wr_en;
   logic [ADDR_W:0]          wr_adr;
   logic [PIX_W-1:0]         wr_data;

   sample_gate #(.GROUP_SKIP(GROUP_SKIP)) sample_gate_inst (
      .clk_llc, .resetx, .vref, .href, .odd, .vpo,
      .samp_valid, .samp_y, .samp_cb, .samp_cr
   );

   // 2 cycles
   ycc_to_rgb ycc_to_rgb_inst (
      .clk_llc, .resetx, .samp_valid, .samp_y, .samp_cb, .samp_cr,
      .rgb_valid, .sum_r, .sum_g, .sum_b
   );

   // 1 cycle
   dark_detect dark_detect_inst (
      .clk_llc, .resetx, .rgb_valid, .sum_r, .sum_g, .sum_b,
      .pix_valid, .pix_data
   );

   frame_writer #(.ADDR_W(ADDR_W)) frame_writer_inst (
      .clk_llc, .resetx, .vref, .odd, .pix_valid, .pix_data,
      .wr_en, .wr_adr, .wr_data, .irq0, .irq1
   );

   frame_buffer #(.ADDR_W(ADDR_W)) frame_buffer_inst (
      .clk_llc, .resetx, .wr_en, .wr_adr, .wr_data,
      .host_rd, .host_adr, .host_data, .host_valid
   );

endmodule

/* hdl/frame_buffer.sv */
// two-bank frame memory with write port and registered host read
`timescale 1ns/1ps

module frame_buffer #(
   parameter int ADDR_W = 15
)
(
   input  logic                          clk_llc,
   input  logic                          resetx,
   input  logic                          wr_en,
   input  logic [ADDR_W:0]               wr_adr,
   input  logic [grabber_pkg::PIX_W-1:0] wr_data,
   input  logic                          host_rd,
   input  logic [ADDR_W:0]               host_adr,
   output logic [grabber_pkg::PIX_W-1:0] host_data,
   output logic                          host_valid
);

   logic [grabber_pkg::PIX_W-1:0] mem [2**(ADDR_W+1)];   // top address bit is the bank

   always_ff @(posedge clk_llc)
   begin
      if (wr_en)
         mem[wr_adr] <= wr_data;
      if (host_rd)
         host_data <= mem[host_adr];   // old word on a same-cycle write
   end

   always_ff @(posedge clk_llc or negedge resetx)
   begin
      if (!resetx)
         host_valid <= 1'b0;
      else
         host_valid <= host_rd;
   end

endmodule

/* hdl/frame_writer.sv */
// bank toggling, write address counter and end-of-field interrupts
`timescale 1ns/1ps

module frame_writer #(
   parameter int ADDR_W = 15
)
(
   input  logic                          clk_llc,
   input  logic                          resetx,
   input  logic                          vref,
   input  logic                          odd,
   input  logic                          pix_valid,
   input  logic [grabber_pkg::PIX_W-1:0] pix_data,
   output logic                          wr_en,
   output logic [ADDR_W:0]               wr_adr,
   output logic [grabber_pkg::PIX_W-1:0] wr_data,
   output logic                          irq0,
   output logic                          irq1
);

   logic              field_act;
   logic              field_d;
   logic              field_rise;
   logic              field_fall;
   logic              fall_d;
   logic              bank;      // bank being filled
   logic [ADDR_W-1:0] pix_adr;

   assign field_act  = odd & vref;
   assign field_rise = field_act & ~field_d;
   assign field_fall = ~field_act & field_d;

   // write goes out in the pix_valid cycle
   assign wr_en   = pix_valid;
   assign wr_adr  = {bank, pix_adr};
   assign wr_data = pix_data;

   //----------------------------------------------------------------------
   // bank, address and 2-cycle interrupt
   //----------------------------------------------------------------------
   always_ff @(posedge clk_llc or negedge resetx)
   begin
      if (!resetx)
      begin
         field_d <= 1'b0;
         fall_d  <= 1'b0;
         bank    <= 1'b0;
         pix_adr <= '0;
         irq0    <= 1'b0;
         irq1    <= 1'b0;
      end
      else
      begin
         field_d <= field_act;
         fall_d  <= field_fall;
         bank    <= bank ^ field_rise;
         if (!field_act)
            pix_adr <= '0;
         else if (pix_valid)
            pix_adr <= pix_adr + 1'b1;
         irq0 <= (field_fall | fall_d) & bank;    // bank 1 finished
         irq1 <= (field_fall | fall_d) & ~bank;   // bank 0 finished
      end
   end

endmodule

/* hdl/dark_detect.sv */
// rgb565 saturation and dark pixel classification
`timescale 1ns/1ps

module dark_detect
(
   input  logic                                clk_llc,
   input  logic                                resetx,
   input  logic                                rgb_valid,
   input  logic signed [grabber_pkg::PROD_W-1:0] sum_r,
   input  logic signed [grabber_pkg::PROD_W-1:0] sum_g,
   input  logic signed [grabber_pkg::PROD_W-1:0] sum_b,
   output logic                                pix_valid,
   output logic        [grabber_pkg::PIX_W-1:0]  pix_data
);

   import grabber_pkg::*;

   localparam int RB_W = OVF_LO - R_LSB;   // 5
   localparam int G_W  = OVF_LO - G_LSB;   // 6

   logic [RB_W-1:0] r, b, g_half;
   logic [RB_W-1:0] d_br, d_gb, d_gr;
   logic [G_W-1:0]  g;
   logic            dark;

   // negative -> 0, overflow -> all ones
   assign r = sum_r[SIGN_BIT] ? '0 : (sum_r[OVF_HI] | sum_r[OVF_LO]) ? '1 : sum_r[R_LSB +: RB_W];
   assign g = sum_g[SIGN_BIT] ? '0 : (sum_g[OVF_HI] | sum_g[OVF_LO]) ? '1 : sum_g[G_LSB +: G_W];
   assign b = sum_b[SIGN_BIT] ? '0 : (sum_b[OVF_HI] | sum_b[OVF_LO]) ? '1 : sum_b[R_LSB +: RB_W];

   assign g_half = g[G_W-1:1];
   assign d_br   = (b < r) ? r - b : b - r;
   assign d_gb   = (g_half < b) ? b - g_half : g_half - b;
   assign d_gr   = (g_half < r) ? r - g_half : g_half - r;

   // near grey and low on all channels
   assign dark = (d_br <= RB_W'(DARK_RB_DIFF)) && (d_gb <= RB_W'(DARK_G_DIFF)) &&
                 (d_gr <= RB_W'(DARK_G_DIFF)) && (r < RB_W'(DARK_R_MAX)) &&
                 (g < G_W'(DARK_G_MAX)) && (b < RB_W'(DARK_B_MAX));

   always_ff @(posedge clk_llc or negedge resetx)
   begin
      if (!resetx)
         pix_valid <= 1'b0;
      else
         pix_valid <= rgb_valid;
   end

   always_ff @(posedge clk_llc)
   begin
      if (rgb_valid)
         pix_data <= dark ? PIX_DARK : PIX_LIGHT;
   end

endmodule

/* hdl/ycc_to_rgb.sv */
// two-stage fixed-point ycbcr to rgb product and sum pipeline
`timescale 1ns/1ps

module ycc_to_rgb
(
   input  logic                                  clk_llc,
   input  logic                                  resetx,
   input  logic                                  samp_valid,
   input  logic        [grabber_pkg::SAMPLE_W-1:0] samp_y,
   input  logic        [grabber_pkg::SAMPLE_W-1:0] samp_cb,
   input  logic        [grabber_pkg::SAMPLE_W-1:0] samp_cr,
   output logic                                  rgb_valid,
   output logic signed [grabber_pkg::PROD_W-1:0]   sum_r,
   output logic signed [grabber_pkg::PROD_W-1:0]   sum_g,
   output logic signed [grabber_pkg::PROD_W-1:0]   sum_b
);

   import grabber_pkg::*;

   logic        [CODE_W-1:0] y_code;
   logic        [CODE_W-1:0] cb_code;
   logic        [CODE_W-1:0] cr_code;
   logic signed [PROD_W-1:0] y_s;
   logic signed [PROD_W-1:0] cb_s;
   logic signed [PROD_W-1:0] cr_s;
   logic signed [PROD_W-1:0] p_y;
   logic signed [PROD_W-1:0] p_rv;
   logic signed [PROD_W-1:0] p_gv;
   logic signed [PROD_W-1:0] p_gu;
   logic signed [PROD_W-1:0] p_bu;
   logic                     valid1;

   assign y_code  = {samp_y, 2'b00};   // x4 scaling
   assign cb_code = {samp_cb, 2'b00};
   assign cr_code = {samp_cr, 2'b00};

   assign y_s  = $signed(PROD_W'(y_code)) - PROD_W'(Y_OFFSET);
   assign cb_s = $signed(PROD_W'(cb_code)) - PROD_W'(C_OFFSET);
   assign cr_s = $signed(PROD_W'(cr_code)) - PROD_W'(C_OFFSET);

   //----------------------------------------------------------------------
   // stage 1 products, stage 2 sums
   //----------------------------------------------------------------------
   always_ff @(posedge clk_llc or negedge resetx)
   begin
      if (!resetx)
      begin
         valid1    <= 1'b0;
         rgb_valid <= 1'b0;
      end
      else
      begin
         valid1    <= samp_valid;
         rgb_valid <= valid1;
      end
   end

   always_ff @(posedge clk_llc)
   begin
      if (samp_valid)
      begin
         p_y  <= y_s  * PROD_W'(K_Y);
         p_rv <= cr_s * PROD_W'(K_RV);
         p_gv <= cr_s * PROD_W'(K_GV);
         p_gu <= cb_s * PROD_W'(K_GU);
         p_bu <= cb_s * PROD_W'(K_BU);
      end
      if (valid1)
      begin
         sum_r <= p_y + p_rv;
         sum_g <= p_y - p_gv - p_gu;
         sum_b <= p_y + p_bu;
      end
   end

endmodule

/* hdl/sample_gate.sv */
// odd field and line selection, byte sequencing and group decimation
`timescale 1ns/1ps

module sample_gate #(
   parameter int GROUP_SKIP = 1
)
(
   input  logic                             clk_llc,
   input  logic                             resetx,
   input  logic                             vref,
   input  logic                             href,
   input  logic                             odd,
   input  logic [grabber_pkg::SAMPLE_W-1:0] vpo,
   output logic                             samp_valid,
   output logic [grabber_pkg::SAMPLE_W-1:0] samp_y,
   output logic [grabber_pkg::SAMPLE_W-1:0] samp_cb,
   output logic [grabber_pkg::SAMPLE_W-1:0] samp_cr
);

   localparam int GRP_W = (GROUP_SKIP > 0) ? $clog2(GROUP_SKIP + 1) : 1;

   logic             field_act;
   logic             href_d;
   logic             href_rise;
   logic             line_tog;
   logic             take;
   logic             grp_end;
   logic [1:0]       code_cnt;  // 0 cb, 1 y, 2 cr, 3 y
   logic [GRP_W-1:0] grp_cnt;

   assign field_act = odd & vref;
   assign href_rise = href & ~href_d;
   // toggle seen as already flipped in the cycle of the href rise
   assign take      = field_act & href & (line_tog ^ href_rise);
   assign grp_end   = take & (code_cnt == 2'd3);

   //----------------------------------------------------------------------
   // line toggle, byte and group counters
   //----------------------------------------------------------------------
   always_ff @(posedge clk_llc or negedge resetx)
   begin
      if (!resetx)
      begin
         href_d     <= 1'b0;
         line_tog   <= 1'b0;
         code_cnt   <= 2'd0;
         grp_cnt    <= '0;
         samp_valid <= 1'b0;
      end
      else
      begin
         href_d     <= href;
         line_tog   <= line_tog ^ href_rise;       // runs across fields
         code_cnt   <= take ? code_cnt + 2'd1 : 2'd0;
         if (!take)
            grp_cnt <= '0;
         else if (grp_end)
            grp_cnt <= (grp_cnt == GRP_W'(GROUP_SKIP)) ? '0 : grp_cnt + 1'b1;
         samp_valid <= grp_end & (grp_cnt == '0); // kept group only
      end
   end

   // second y of a group is never captured
   always_ff @(posedge clk_llc)
   begin
      if (take && code_cnt == 2'd0) samp_cb <= vpo;
      if (take && code_cnt == 2'd1) samp_y  <= vpo;
      if (take && code_cnt == 2'd2) samp_cr <= vpo;
   end

endmodule

/* hdl/grabber_pkg.sv */
// widths, conversion coefficients, offsets, saturation positions and dark thresholds
package grabber_pkg;

   //----------------------------------------------------------------------
   // data widths
   //----------------------------------------------------------------------
   localparam int SAMPLE_W = 8;    // one decoder byte
   localparam int CODE_W   = 10;   // byte with two zero bits below
   localparam int PROD_W   = 21;   // signed product / sum
   localparam int PIX_W    = 16;   // rgb565 word

   //----------------------------------------------------------------------
   // ycbcr to rgb coefficients, 8 fraction bits
   //----------------------------------------------------------------------
   localparam int K_Y  = 298;      // 1.164
   localparam int K_RV = 408;      // 1.596
   localparam int K_GV = 208;      // 0.813
   localparam int K_GU = 100;      // 0.392
   localparam int K_BU = 516;      // 2.017

   localparam int Y_OFFSET = 64;   // black level of scaled luma
   localparam int C_OFFSET = 512;  // zero point of scaled chroma

   // bit positions inside a sum
   localparam int SIGN_BIT = 20;
   localparam int OVF_HI   = 19;
   localparam int OVF_LO   = 18;
   localparam int R_LSB    = 13;   // red and blue keep 5 bits
   localparam int G_LSB    = 12;   // green keeps 6 bits

   //----------------------------------------------------------------------
   // dark pixel limits
   //----------------------------------------------------------------------
   localparam int DARK_RB_DIFF = 2;
   localparam int DARK_G_DIFF  = 3;   // against G/2
   localparam int DARK_R_MAX   = 8;
   localparam int DARK_G_MAX   = 15;
   localparam int DARK_B_MAX   = 8;

   localparam logic [PIX_W-1:0] PIX_DARK  = 16'h0000;
   localparam logic [PIX_W-1:0] PIX_LIGHT = 16'hFFFF;

endpackage
